/* hw/baud_generator.sv */
module baud_generator #(
    parameter int SYSTEM_FREQUENCY = 100_000_000,
    parameter int SAMPLING_RATE    = 16
) (
    input  logic                clk,
    input  logic                reset_n,
    input  uart_pkg::baud_sel_t baud_sel,
    output logic                tick_tx,
    output logic                tick_rx
);

    localparam int unsigned DIV_4800   = SYSTEM_FREQUENCY / 4800;
    localparam int unsigned DIV_9600   = SYSTEM_FREQUENCY / 9600;
    localparam int unsigned DIV_14400  = SYSTEM_FREQUENCY / 14400;
    localparam int unsigned DIV_19200  = SYSTEM_FREQUENCY / 19200;
    localparam int unsigned DIV_38400  = SYSTEM_FREQUENCY / 38400;
    localparam int unsigned DIV_57600  = SYSTEM_FREQUENCY / 57600;
    localparam int unsigned DIV_115200 = SYSTEM_FREQUENCY / 115200;
    localparam int unsigned DIV_230400 = SYSTEM_FREQUENCY / 230400;

    logic [31:0] div_tx;
    logic [31:0] div_rx;
    logic [31:0] counter_tx;
    logic [31:0] counter_rx;

    // **************************************************
    // Rate decode.
    // **************************************************
    always_comb begin
        case (baud_sel)
            uart_pkg::BAUD_4800:   div_tx = DIV_4800;
            uart_pkg::BAUD_9600:   div_tx = DIV_9600;
            uart_pkg::BAUD_14400:  div_tx = DIV_14400;
            uart_pkg::BAUD_19200:  div_tx = DIV_19200;
            uart_pkg::BAUD_38400:  div_tx = DIV_38400;
            uart_pkg::BAUD_57600:  div_tx = DIV_57600;
            uart_pkg::BAUD_115200: div_tx = DIV_115200;
            uart_pkg::BAUD_230400: div_tx = DIV_230400;
            default:               div_tx = DIV_115200;
        endcase
        div_rx = div_tx / SAMPLING_RATE; // Constant per select value.
    end

    // **************************************************
    // Strobe counters.
    // **************************************************
    // A counter past the new divisor after a rate change wraps at once.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            counter_tx <= '0;
            tick_tx    <= 1'b0;
        end else if (counter_tx >= div_tx - 1) begin
            counter_tx <= '0;
            tick_tx    <= 1'b1;
        end else begin
            counter_tx <= counter_tx + 1;
            tick_tx    <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            counter_rx <= '0;
            tick_rx    <= 1'b0;
        end else if (counter_rx >= div_rx - 1) begin
            counter_rx <= '0;
            tick_rx    <= 1'b1; // Stays high when the divisor is 1.
        end else begin
            counter_rx <= counter_rx + 1;
            tick_rx    <= 1'b0;
        end
    end

endmodule

/* hw/uart_pkg.sv */
package uart_pkg;

    // Payload bits per frame.
    parameter int DATA_BITS = 8;

    // Rate select encodings.
    typedef enum logic [2:0] {
        BAUD_4800   = 3'd0,
        BAUD_9600   = 3'd1,
        BAUD_14400  = 3'd2,
        BAUD_19200  = 3'd3,
        BAUD_38400  = 3'd4,
        BAUD_57600  = 3'd5,
        BAUD_115200 = 3'd6,
        BAUD_230400 = 3'd7
    } baud_sel_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

/* hw/uart_rx.sv */
module uart_rx #(
    parameter int SAMPLING_RATE = 16
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           tick,
    input  logic                           rxd,
    output logic [uart_pkg::DATA_BITS-1:0] data,
    output logic                           valid,
    output logic                           frame_error
);

    localparam int CNT_W = (SAMPLING_RATE > 2) ? $clog2(SAMPLING_RATE) : 1;
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(SAMPLING_RATE / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(SAMPLING_RATE - 1);
    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(uart_pkg::DATA_BITS - 1);

    uart_pkg::rx_state_t state;
    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;
    logic start_edge;
    logic sample;
    logic [CNT_W-1:0] os_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [uart_pkg::DATA_BITS-1:0] shift_reg;

    // **************************************************
    // Input synchronizer and edge detect.
    // **************************************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // A low line only starts a frame after it has been seen high.
    assign start_edge = rxd_prev && !rxd_sync;

    // Half a bit into the start bit, then one full bit per sample.
    assign sample = tick &&
                    (os_cnt == ((state == uart_pkg::RX_START) ? HALF_LAST : FULL_LAST));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            os_cnt <= '0;
        end else if (state == uart_pkg::RX_IDLE || sample) begin
            os_cnt <= '0;
        end else if (tick) begin
            os_cnt <= os_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sample && state == uart_pkg::RX_DATA) begin
            shift_reg <= {rxd_sync, shift_reg[uart_pkg::DATA_BITS-1:1]}; // LSB first.
        end
    end

    // **************************************************
    // Receive FSM.
    // **************************************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= uart_pkg::RX_IDLE;
            bit_cnt     <= '0;
            data        <= '0;
            valid       <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (start_edge) state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: begin
                    if (sample) begin
                        // High at mid start bit is a glitch.
                        state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                        bit_cnt <= '0;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (sample) begin
                        if (bit_cnt == LAST_BIT) state <= uart_pkg::RX_STOP;
                        else bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (sample) begin
                        state       <= uart_pkg::RX_IDLE;
                        data        <= shift_reg;
                        valid       <= 1'b1;
                        frame_error <= !rxd_sync; // Stop bit read 0.
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

/* hw/uart_top.sv */
module uart_top #(
    parameter int SYSTEM_FREQUENCY = 100_000_000,
    parameter int SAMPLING_RATE    = 16
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  uart_pkg::baud_sel_t            baud_sel,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    input  logic                           tx_start,
    input  logic                           rxd,
    output logic                           tx_busy,
    output logic                           txd,
    output logic [uart_pkg::DATA_BITS-1:0] rx_data,
    output logic                           rx_valid,
    output logic                           rx_frame_error
);

    logic tick_tx;
    logic tick_rx;

    baud_generator #(
        .SYSTEM_FREQUENCY (SYSTEM_FREQUENCY),
        .SAMPLING_RATE    (SAMPLING_RATE)
    ) u_baud (
        .clk      (clk),
        .reset_n  (reset_n),
        .baud_sel (baud_sel),
        .tick_tx  (tick_tx),
        .tick_rx  (tick_rx)
    );

    uart_tx u_tx (
        .clk     (clk),
        .reset_n (reset_n),
        .tick    (tick_tx),
        .data    (tx_data),
        .start   (tx_start),
        .busy    (tx_busy),
        .txd     (txd)
    );

    // Receiver runs on the oversampling strobe.
    uart_rx #(
        .SAMPLING_RATE (SAMPLING_RATE)
    ) u_rx (
        .clk         (clk),
        .reset_n     (reset_n),
        .tick        (tick_rx),
        .rxd         (rxd),
        .data        (rx_data),
        .valid       (rx_valid),
        .frame_error (rx_frame_error)
    );

endmodule

/* hw/uart_tx.sv */
module uart_tx (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           tick,
    input  logic [uart_pkg::DATA_BITS-1:0] data,
    input  logic                           start,
    output logic                           busy,
    output logic                           txd
);

    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(uart_pkg::DATA_BITS - 1);

    uart_pkg::tx_state_t state;
    logic [uart_pkg::DATA_BITS-1:0] shift_reg;
    logic [BIT_W-1:0] bit_cnt;
    logic accept;

    assign accept = start && !busy;

    // Loaded on accept, one bit out per tick while sending.
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= data;
        end else if (tick && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // **************************************************
    // Frame FSM.
    // **************************************************
    // Idle with busy high means a byte waits for the next tick.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= uart_pkg::TX_IDLE;
            busy    <= 1'b0;
            txd     <= 1'b1;
            bit_cnt <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (accept) begin
                        busy <= 1'b1;
                    end else if (busy && tick) begin
                        state <= uart_pkg::TX_START;
                        txd   <= 1'b0; // Start bit.
                    end
                end
                uart_pkg::TX_START: begin
                    if (tick) begin
                        state   <= uart_pkg::TX_DATA;
                        txd     <= shift_reg[0];
                        bit_cnt <= '0;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (tick) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= uart_pkg::TX_STOP;
                            txd   <= 1'b1; // Stop bit.
                        end else begin
                            txd     <= shift_reg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (tick) begin
                        state <= uart_pkg::TX_IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the UART testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module uart_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vuart_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* src.f */
hw/uart_pkg.sv
hw/baud_generator.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
tests/uart_checker.sv
tests/uart_monitor.sv
tests/uart_tb.sv

/* tests/uart_checker.sv */
module uart_checker (
    input logic clk,
    input logic reset_n,
    input logic tx_start,
    input logic tx_busy,
    input logic txd,
    input logic rx_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // **************************************************
    // Handshake and line rules.
    // **************************************************
    valid_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        rx_valid |=> !rx_valid)
        else begin
            $error("rx_valid held high for more than one cycle");
            failures++;
        end

    idle_line_high: assert property (@(posedge clk) disable iff (!reset_n)
        !tx_busy |-> txd)
        else begin
            $error("txd low while tx_busy is low");
            failures++;
        end

    busy_follows_start: assert property (@(posedge clk) disable iff (!reset_n)
        (tx_start && !tx_busy) |=> tx_busy)
        else begin
            $error("tx_busy did not rise after an accepted tx_start");
            failures++;
        end

endmodule

bind uart_top uart_checker u_checker (
    .clk      (clk),
    .reset_n  (reset_n),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .txd      (txd),
    .rx_valid (rx_valid)
);

/* tests/uart_monitor.sv */
module uart_monitor (
    input  logic                           clk,
    input  logic                           reset_n,
    input  uart_pkg::baud_sel_t            baud_sel,
    input  logic                           txd,
    input  logic                           rx_valid,
    input  logic [uart_pkg::DATA_BITS-1:0] rx_data,
    input  logic                           rx_frame_error,
    input  logic                           push_tx,
    input  logic                           push_rx,
    input  logic [uart_pkg::DATA_BITS-1:0] exp_data,
    input  logic                           exp_frame_error,
    output int                             tx_errors,
    output int                             rx_errors,
    output int                             tx_frames,
    output int                             rx_frames
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB = uart_pkg::DATA_BITS;

    logic [NB-1:0] tx_q[$];
    logic [NB:0]   rx_q[$];    // Frame error flag above the byte.
    logic [NB+1:0] frame;
    logic [NB:0]   rx_exp;
    logic          tx_active;
    logic          prev_txd;
    int            cyc;
    int            bit_len;

    // Clock cycles per bit at 3.6864 MHz.
    function automatic int expected_bit_cycles(uart_pkg::baud_sel_t sel);
        case (sel)
            uart_pkg::BAUD_4800:   return 3_686_400 / 4800;
            uart_pkg::BAUD_9600:   return 3_686_400 / 9600;
            uart_pkg::BAUD_14400:  return 3_686_400 / 14400;
            uart_pkg::BAUD_19200:  return 3_686_400 / 19200;
            uart_pkg::BAUD_38400:  return 3_686_400 / 38400;
            uart_pkg::BAUD_57600:  return 3_686_400 / 57600;
            uart_pkg::BAUD_115200: return 3_686_400 / 115200;
            default:               return 3_686_400 / 230400;
        endcase
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_active = 1'b0;
            prev_txd  = 1'b1;
            tx_errors <= 0;
            rx_errors <= 0;
            tx_frames <= 0;
            rx_frames <= 0;
        end else begin
            if (push_tx) tx_q.push_back(exp_data);
            if (push_rx) rx_q.push_back({exp_frame_error, exp_data});

            // **************************************************
            // Transmit frame decode.
            // **************************************************
            if (tx_active) begin
                if (txd !== frame[cyc / bit_len]) begin
                    $display("ERR %0t: txd bit %0d is %b, expected %b", $time,
                             cyc / bit_len, txd, frame[cyc / bit_len]);
                    tx_errors <= tx_errors + 1;
                end
                cyc = cyc + 1;
                if (cyc == (NB + 2) * bit_len) tx_active = 1'b0;
            end else if (prev_txd && !txd) begin
                if (tx_q.size() == 0) begin
                    $display("ERR %0t: frame on txd with no accepted start", $time);
                    tx_errors <= tx_errors + 1;
                end else begin
                    frame     = {1'b1, tx_q.pop_front(), 1'b0};
                    bit_len   = expected_bit_cycles(baud_sel);
                    cyc       = 1; // This cycle is the first of the start bit.
                    tx_active = 1'b1;
                    tx_frames <= tx_frames + 1;
                end
            end
            prev_txd = txd;

            // **************************************************
            // Receive comparison.
            // **************************************************
            if (rx_valid) begin
                rx_frames <= rx_frames + 1;
                if (rx_q.size() == 0) begin
                    $display("ERR %0t: rx_valid with no expected byte", $time);
                    rx_errors <= rx_errors + 1;
                end else begin
                    rx_exp = rx_q.pop_front();
                    if (rx_data !== rx_exp[NB-1:0] || rx_frame_error !== rx_exp[NB]) begin
                        $display("ERR %0t: received %h error %b, expected %h error %b",
                                 $time, rx_data, rx_frame_error, rx_exp[NB-1:0], rx_exp[NB]);
                        rx_errors <= rx_errors + 1;
                    end
                end
            end
        end
    end

endmodule

/* tests/uart_tb.sv */
module uart_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NB         = uart_pkg::DATA_BITS;
    localparam int FAST_BIT   = 3_686_400 / 230_400;
    localparam int MAX_CYCLES = 150_000; // About twice the full run.

    logic                clk;
    logic                reset_n;
    uart_pkg::baud_sel_t baud_sel;
    logic [NB-1:0]       tx_data;
    logic                tx_start;
    logic                rxd;
    logic                tx_busy;
    logic                txd;
    logic [NB-1:0]       rx_data;
    logic                rx_valid;
    logic                rx_frame_error;
    logic                loopback;
    logic                forced_rxd;
    logic                push_tx;
    logic                push_rx;
    logic [NB-1:0]       exp_data;
    logic                exp_frame_error;
    int tx_errors;
    int rx_errors;
    int tx_frames;
    int rx_frames;
    int tb_errors   = 0;
    int accepted    = 0;
    int expected_rx = 0;
    int cycles      = 0;

    assign rxd = loopback ? txd : forced_rxd;

    uart_top #(
        .SYSTEM_FREQUENCY (3_686_400),
        .SAMPLING_RATE    (16)
    ) DUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .baud_sel       (baud_sel),
        .tx_data        (tx_data),
        .tx_start       (tx_start),
        .rxd            (rxd),
        .tx_busy        (tx_busy),
        .txd            (txd),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_frame_error (rx_frame_error)
    );

    uart_monitor mon (
        .clk             (clk),
        .reset_n         (reset_n),
        .baud_sel        (baud_sel),
        .txd             (txd),
        .rx_valid        (rx_valid),
        .rx_data         (rx_data),
        .rx_frame_error  (rx_frame_error),
        .push_tx         (push_tx),
        .push_rx         (push_rx),
        .exp_data        (exp_data),
        .exp_frame_error (exp_frame_error),
        .tx_errors       (tx_errors),
        .rx_errors       (rx_errors),
        .tx_frames       (tx_frames),
        .rx_frames       (rx_frames)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_idle_outputs(input string when);
        if (txd !== 1'b1 || tx_busy !== 1'b0 || rx_valid !== 1'b0 || rx_frame_error !== 1'b0) begin
            $display("ERR %0t: outputs not idle %s (txd %b busy %b valid %b ferr %b)", $time,
                     when, txd, tx_busy, rx_valid, rx_frame_error);
            tb_errors++;
        end
    endtask

    // Called just after a rising edge.
    task automatic send_byte(input logic [NB-1:0] b);
        while (tx_busy) @(posedge clk);
        tx_start        <= 1'b1;
        tx_data         <= b;
        push_tx         <= 1'b1;
        push_rx         <= loopback;
        exp_data        <= b;
        exp_frame_error <= 1'b0;
        accepted++;
        if (loopback) expected_rx++;
        @(posedge clk);
        tx_start <= 1'b0;
        push_tx  <= 1'b0;
        push_rx  <= 1'b0;
        @(posedge clk);
    endtask

    // Serializes one frame on rxd at the fastest rate.
    task automatic send_forced(input logic [NB-1:0] b, input logic stop_bit);
        logic [NB+1:0] bits;
        bits = {stop_bit, b, 1'b0};
        push_rx         <= 1'b1;
        exp_data        <= b;
        exp_frame_error <= !stop_bit;
        expected_rx++;
        @(posedge clk);
        push_rx <= 1'b0;
        for (int i = 0; i < NB + 2; i++) begin
            forced_rxd <= bits[i];
            repeat (FAST_BIT) @(posedge clk);
        end
        forced_rxd <= 1'b1;
        repeat (2 * FAST_BIT) @(posedge clk);
    endtask

    task automatic wait_idle();
        while (rx_frames != expected_rx || tx_busy) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    initial begin
        logic [NB-1:0] first;
        int total;
        void'($urandom(32'h309a_0719));
        reset_n         = 1'b0;
        baud_sel        = uart_pkg::BAUD_4800;
        tx_data         = '0;
        tx_start        = 1'b0;
        loopback        = 1'b1;
        forced_rxd      = 1'b1;
        push_tx         = 1'b0;
        push_rx         = 1'b0;
        exp_data        = '0;
        exp_frame_error = 1'b0;

        repeat (2) @(posedge clk);
        check_idle_outputs("during reset");
        reset_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_idle_outputs("after reset");

        // Loopback at every rate.
        for (int s = 0; s < 8; s++) begin
            baud_sel <= uart_pkg::baud_sel_t'(s[2:0]);
            repeat (4) @(posedge clk);
            repeat (4) send_byte(NB'($urandom));
            wait_idle();
        end

        // Frame error, then a good frame clears the flag.
        loopback <= 1'b0;
        @(posedge clk);
        send_forced(8'hA5, 1'b0);
        send_forced(8'h3C, 1'b1);
        wait_idle();

        // A second start mid-frame is dropped.
        loopback <= 1'b1;
        @(posedge clk);
        first = NB'($urandom);
        send_byte(first);
        repeat (3 * FAST_BIT) @(posedge clk);
        tx_start <= 1'b1;
        tx_data  <= ~first;
        @(posedge clk);
        tx_start <= 1'b0;
        wait_idle();
        repeat (4 * FAST_BIT) @(posedge clk);

        if (tx_frames != accepted) begin
            $display("ERR %0t: %0d frames on txd for %0d accepted starts", $time,
                     tx_frames, accepted);
            tb_errors++;
        end

        total = tx_errors + rx_errors + tb_errors + DUT.u_checker.failures;
        $display("Errors: tx %0d, rx %0d, tb %0d, assertions %0d", tx_errors, rx_errors,
                 tb_errors, DUT.u_checker.failures);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
